/* source/icache_pkg.sv */
package icache_pkg;

    // fetch address fields are tag 31..15, index 14..6, bank 5..4
    localparam int ADDR_W    = 32;
    localparam int TAG_W     = 17;
    localparam int INDEX_W   = 9;
    localparam int NUM_SETS  = 512;
    localparam int BANK_W    = 2;
    localparam int NUM_BANKS = 4;
    localparam int OFFSET_W  = 6;

    // one fetch word per bank, four banks per line
    localparam int WORD_W    = 128;
    localparam int LINE_W    = 512;
    localparam int NUM_WAYS  = 2;

    // replacement lfsr restarts from all ones
    localparam logic [7:0] LFSR_SEED = 8'hFF;

    // lookup controller state codes
    localparam logic [1:0] IDLE        = 2'd0;
    localparam logic [1:0] LOOKUP      = 2'd1;
    localparam logic [1:0] READ_CACHE  = 2'd2;
    localparam logic [1:0] REFILL_WAIT = 2'd3;

    typedef logic [ADDR_W-1:0]  fetch_addr_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [BANK_W-1:0]  bank_t;

    // two ways fit in one bit
    typedef logic               way_t;
    typedef logic [WORD_W-1:0]  fetch_word_t;

    // memory line seen flat or as banks
    // bank 0 sits in the low 128 bits
    typedef union packed {
        logic [LINE_W-1:0]           raw;
        fetch_word_t [NUM_BANKS-1:0] bank;
    } cache_line_u;

endpackage

/* source/icache_tag_array.sv */
`timescale 1ns/1ps

module icache_tag_array
    import icache_pkg::*;
(
    input  logic                clock,
    input  logic                reset_n,
    input  logic                read_en,
    input  index_t              read_index,
    output tag_t [NUM_WAYS-1:0] read_tags,
    output logic [NUM_WAYS-1:0] read_valid,
    input  logic                write_en,
    input  index_t              write_index,
    input  way_t                write_way,
    input  tag_t                write_tag
);

    // tag storage per set and way
    tag_t tag_mem [NUM_SETS][NUM_WAYS];

    // valid bits live in flops
    // cleared together on reset
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;

    always_ff @(posedge clock) begin
        if (write_en) begin
            tag_mem[write_index][write_way] <= write_tag;
        end
    end

    // both ways of the set come out one cycle later
    always_ff @(posedge clock) begin
        if (read_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                read_tags[w] <= tag_mem[read_index][w];
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q    <= '0;
            read_valid <= '0;
        end else begin
            // a refill marks its way valid
            if (write_en) begin
                valid_q[write_index][write_way] <= 1'b1;
            end
            // valid bits follow the tag read
            if (read_en) begin
                read_valid <= valid_q[read_index];
            end
        end
    end

endmodule

/* source/icache_data_array.sv */
`timescale 1ns/1ps

module icache_data_array
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        read_en,
    input  index_t      read_index,
    input  way_t        read_way,
    input  bank_t       read_bank,
    output fetch_word_t read_word,
    input  logic        write_en,
    input  index_t      write_index,
    input  way_t        write_way,
    input  cache_line_u write_line
);

    // one memory per bank
    // entry address is way then set
    fetch_word_t bank_mem [NUM_BANKS][NUM_WAYS*NUM_SETS];

    always_ff @(posedge clock) begin
        // refill writes every bank of the victim way
        if (write_en) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                bank_mem[b][{write_way, write_index}] <= write_line.bank[b];
            end
        end
        // only the addressed bank is read
        // word holds until the next read
        if (read_en) begin
            read_word <= bank_mem[read_bank][{read_way, read_index}];
        end
    end

    // hit reads and refill writes come from different blocks
    // they must never share a cycle
    assert property (@(posedge clock) !(read_en && write_en))
        else $error("data array read and write in the same cycle");

endmodule

/* source/icache_refill_unit.sv */
`timescale 1ns/1ps

module icache_refill_unit
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        flush,
    input  logic        refill_start,
    input  fetch_addr_t refill_addr,
    input  way_t        refill_way,
    output logic        refill_busy,
    output logic        refill_done,
    output fetch_word_t refill_word,
    output logic        mem_req_valid,
    input  logic        mem_req_ready,
    output fetch_addr_t mem_req_addr,
    input  logic        mem_done,
    input  cache_line_u mem_read_line,
    output logic        tag_write_en,
    output logic        data_write_en,
    output index_t      write_index,
    output way_t        write_way,
    output tag_t        write_tag,
    output cache_line_u write_line
);

    fetch_addr_t addr_q;
    way_t        way_q;
    logic        busy_q;
    logic        req_valid_q;
    logic        line_in;

    // line arrives and goes into the arrays at this edge
    assign line_in = busy_q && mem_done;

    // miss address and victim way
    always_ff @(posedge clock) begin
        if (refill_start) begin
            addr_q <= refill_addr;
            way_q  <= refill_way;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy_q      <= 1'b0;
            req_valid_q <= 1'b0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= line_in;
            if (refill_start) begin
                busy_q      <= 1'b1;
                req_valid_q <= 1'b1;
            end else if (req_valid_q && mem_req_ready) begin
                // memory took it, now wait for the line
                req_valid_q <= 1'b0;
            end else if (req_valid_q && flush) begin
                // not accepted yet so the read is dropped
                req_valid_q <= 1'b0;
                busy_q      <= 1'b0;
            end
            if (line_in) begin
                busy_q <= 1'b0;
            end
        end
    end

    // critical word for the waiting fetch
    always_ff @(posedge clock) begin
        if (line_in) begin
            refill_word <= mem_read_line.bank[addr_q[OFFSET_W-1 -: BANK_W]];
        end
    end

    assign refill_busy   = busy_q;
    assign mem_req_valid = req_valid_q;

    // line aligned read request
    assign mem_req_addr  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // tag and line are written together
    assign tag_write_en  = line_in;
    assign data_write_en = line_in;
    assign write_index   = addr_q[OFFSET_W +: INDEX_W];
    assign write_way     = way_q;
    assign write_tag     = addr_q[ADDR_W-1 -: TAG_W];
    assign write_line    = mem_read_line;

    // request address holds until memory takes it
    assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid && !mem_req_ready |=> $stable(mem_req_addr))
        else $error("mem_req_addr changed while waiting for ready");

    // every completion belongs to a read issued here
    assert property (@(posedge clock) disable iff (!reset_n) mem_done |-> busy_q)
        else $error("mem_done while refill unit idle");

endmodule

/* source/icache_lookup_ctrl.sv */
`timescale 1ns/1ps

module icache_lookup_ctrl
    import icache_pkg::*;
(
    input  logic                clock,
    input  logic                reset_n,
    input  logic                flush,
    input  logic                fetch_valid,
    output logic                fetch_ready,
    input  fetch_addr_t         fetch_addr,
    output logic                fetch_done,
    output fetch_word_t         fetch_data,
    output logic                tag_read_en,
    output index_t              tag_read_index,
    input  tag_t [NUM_WAYS-1:0] read_tags,
    input  logic [NUM_WAYS-1:0] read_valid,
    output logic                data_read_en,
    output index_t              data_read_index,
    output way_t                data_read_way,
    output bank_t               data_read_bank,
    input  fetch_word_t         read_word,
    output logic                refill_start,
    output fetch_addr_t         refill_addr,
    output way_t                refill_way,
    input  logic                refill_busy,
    input  logic                refill_done,
    input  fetch_word_t         refill_word
);

    logic [1:0]          state;
    logic [1:0]          next_state;
    fetch_addr_t         addr_q;
    logic                word_valid;
    logic [7:0]          lfsr;
    logic [NUM_WAYS-1:0] way_hit;
    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic                accept;

    // new fetch only when idle and no line read is outstanding
    assign fetch_ready = (state == IDLE) && !refill_busy && !flush;
    assign accept      = fetch_valid && fetch_ready;

    // tag read straight from the incoming address
    assign tag_read_en    = accept;
    assign tag_read_index = fetch_addr[OFFSET_W +: INDEX_W];

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q <= fetch_addr;
        end
    end

    // compare both ways against the latched tag
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = read_valid[w] && (read_tags[w] == addr_q[ADDR_W-1 -: TAG_W]);
        end
    end

    assign hit     = |way_hit;
    // with two ways the way 1 match bit is the way number
    assign hit_way = way_hit[1];

    // first invalid way, else the lfsr decides
    assign victim_way = !read_valid[0] ? 1'b0 :
                        !read_valid[1] ? 1'b1 : lfsr[0];

    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
        end
    end

    // hit path reads one bank of the matching way
    assign data_read_en    = (state == LOOKUP) && hit;
    assign data_read_index = addr_q[OFFSET_W +: INDEX_W];
    assign data_read_way   = hit_way;
    assign data_read_bank  = addr_q[OFFSET_W-1 -: BANK_W];

    // miss hands the line fetch to the refill unit
    assign refill_start = (state == LOOKUP) && !hit && !flush;
    assign refill_addr  = addr_q;
    assign refill_way   = victim_way;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:        if (accept) next_state = LOOKUP;
            LOOKUP:      next_state = hit ? READ_CACHE : REFILL_WAIT;
            READ_CACHE:  if (word_valid) next_state = IDLE;
            REFILL_WAIT: if (refill_done) next_state = IDLE;
            default:     next_state = IDLE;
        endcase
    end

    // flush abandons the request
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else if (flush) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // array word settles in the first READ_CACHE cycle
    // done goes out in the second
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= (state == READ_CACHE) && !word_valid && !flush;
        end
    end

    assign fetch_done = !flush && (((state == READ_CACHE) && word_valid) ||
                                   ((state == REFILL_WAIT) && refill_done));

    // data is zero outside the done cycle
    always_comb begin
        fetch_data = '0;
        if (fetch_done) begin
            fetch_data = (state == READ_CACHE) ? read_word : refill_word;
        end
    end

    // a returned line only meets a waiting miss or one abandoned by flush
    assert property (@(posedge clock) disable iff (!reset_n)
        refill_done |-> ((state == REFILL_WAIT) || (state == IDLE)))
        else $error("refill_done with no miss waiting");

endmodule

/* source/icache_top.sv */
`timescale 1ns/1ps

module icache_top
    import icache_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        flush,
    input  logic        fetch_valid,
    output logic        fetch_ready,
    input  fetch_addr_t fetch_addr,
    output logic        fetch_done,
    output fetch_word_t fetch_data,
    output logic        mem_req_valid,
    input  logic        mem_req_ready,
    output fetch_addr_t mem_req_addr,
    input  logic        mem_done,
    input  cache_line_u mem_read_line
);

    // controller to arrays
    logic                tag_read_en;
    index_t              tag_read_index;
    tag_t [NUM_WAYS-1:0] read_tags;
    logic [NUM_WAYS-1:0] read_valid;
    logic                data_read_en;
    index_t              data_read_index;
    way_t                data_read_way;
    bank_t               data_read_bank;
    fetch_word_t         read_word;

    // controller and refill handoff
    logic                refill_start;
    fetch_addr_t         refill_addr;
    way_t                refill_way;
    logic                refill_busy;
    logic                refill_done;
    fetch_word_t         refill_word;

    // refill writes into both arrays
    logic                tag_write_en;
    logic                data_write_en;
    index_t              write_index;
    way_t                write_way;
    tag_t                write_tag;
    cache_line_u         write_line;

    icache_lookup_ctrl u_lookup_ctrl (.*);

    icache_tag_array u_tag_array (
        .*,
        .read_en    (tag_read_en),
        .read_index (tag_read_index),
        .write_en   (tag_write_en)
    );

    icache_data_array u_data_array (
        .*,
        .read_en    (data_read_en),
        .read_index (data_read_index),
        .read_way   (data_read_way),
        .read_bank  (data_read_bank),
        .write_en   (data_write_en)
    );

    icache_refill_unit u_refill_unit (.*);

endmodule

/* tests/icache_mem_model.sv */
`timescale 1ns/1ps

module icache_mem_model
    import icache_pkg::*;
#(
    parameter int unsigned SEED = 95
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        mem_req_valid,
    output logic        mem_req_ready,
    input  fetch_addr_t mem_req_addr,
    output logic        mem_done,
    output cache_line_u mem_read_line
);

    // each 32-bit lane holds its own byte address, salted
    function automatic cache_line_u fill_line(input fetch_addr_t base);
        cache_line_u line;
        for (int lane = 0; lane < LINE_W / 32; lane++) begin
            line.raw[32*lane +: 32] = (base + 32'(4 * lane)) ^ 32'h5A5A_0000;
        end
        return line;
    endfunction

    // one line read, from first sight of the request to mem_done
    task automatic serve_read();
        int unsigned ready_delay;
        int unsigned done_delay;
        fetch_addr_t line_addr;
        logic        dropped;
        ready_delay = $urandom_range(5, 0);
        done_delay  = $urandom_range(10, 2);
        dropped     = 1'b0;
        // a flush may pull the request back while ready is held off
        for (int i = 0; i < ready_delay && !dropped; i++) begin
            @(negedge clock);
            dropped = !mem_req_valid;
        end
        if (!dropped) begin
            line_addr = mem_req_addr;
            mem_req_ready <= 1'b1;
            @(negedge clock);
            // taken at the rising edge just passed
            mem_req_ready <= 1'b0;
            repeat (done_delay - 1) @(negedge clock);
            mem_done      <= 1'b1;
            mem_read_line <= fill_line(line_addr);
            @(negedge clock);
            mem_done      <= 1'b0;
            mem_read_line <= '0;
        end
    endtask

    // outputs change on the falling edge only
    initial begin
        void'($urandom(SEED));
        mem_req_ready = 1'b0;
        mem_done      = 1'b0;
        mem_read_line = '0;
        forever begin
            @(negedge clock);
            if (reset_n && mem_req_valid) begin
                serve_read();
            end
        end
    end

endmodule

/* tests/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
();

    typedef enum logic [1:0] {EXPECT_HIT, EXPECT_MISS, EXPECT_EITHER} outcome_e;

    logic        clock;
    logic        reset_n;
    logic        flush;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_addr_t fetch_addr;
    logic        fetch_done;
    fetch_word_t fetch_data;
    logic        mem_req_valid;
    logic        mem_req_ready;
    fetch_addr_t mem_req_addr;
    logic        mem_done;
    cache_line_u mem_read_line;

    // request table, one entry per fetch
    fetch_addr_t tab_addr[$];
    outcome_e    tab_outcome[$];
    logic        tab_flush[$];
    fetch_word_t tab_word[$];
    logic        seen_miss[$];
    int          evict_first;

    // memory side bookkeeping
    int          mem_accepts;
    logic        req_seen;
    fetch_addr_t req_seen_addr;
    fetch_addr_t last_req_addr;

    icache_top UUT (.*);

    icache_mem_model #(.SEED(95)) u_mem_model (.*);

    always #10 clock = ~clock;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        fail_run($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    task automatic check_word(input fetch_word_t actual, input fetch_word_t expected);
        if (actual !== expected)
            report_mismatch($sformatf("fetch_data %h, expected %h", actual, expected));
    endtask

    task automatic check_miss(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            report_mismatch($sformatf("%s: miss %b, expected %b", what, actual, expected));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            report_mismatch($sformatf("%s is %b, expected %b", what, actual, expected));
    endtask

    task automatic check_addr(input fetch_addr_t actual, input fetch_addr_t expected,
                              input string what);
        if (actual !== expected)
            report_mismatch($sformatf("%s: %h, expected %h", what, actual, expected));
    endtask

    task automatic check_cycles(input int actual, input int expected);
        if (actual != expected)
            report_mismatch($sformatf("hit done after %0d edges, expected %0d",
                                      actual, expected));
    endtask

    // four lanes of the bank, each its byte address salted
    function automatic fetch_word_t expected_word(input fetch_addr_t addr);
        fetch_word_t word;
        for (int j = 0; j < 4; j++) begin
            word[32*j +: 32] = ({addr[ADDR_W-1:4], 4'b0000} + 32'(4 * j)) ^ 32'h5A5A_0000;
        end
        return word;
    endfunction

    function automatic fetch_addr_t make_addr(input tag_t tag, input index_t index,
                                              input bank_t bank, input logic [3:0] byte_sel);
        return {tag, index, bank, byte_sel};
    endfunction

    task automatic add_entry(input fetch_addr_t addr, input outcome_e outcome,
                             input logic flush_after);
        tab_addr.push_back(addr);
        tab_outcome.push_back(outcome);
        tab_flush.push_back(flush_after);
        tab_word.push_back(expected_word(addr));
    endtask

    task automatic build_table();
        index_t index;
        // line a, cold miss then its other banks
        add_entry(make_addr(1, 5, 2, 0), EXPECT_MISS, 1'b0);
        add_entry(make_addr(1, 5, 0, 4), EXPECT_HIT, 1'b0);
        add_entry(make_addr(1, 5, 1, 8), EXPECT_HIT, 1'b0);
        add_entry(make_addr(1, 5, 3, 12), EXPECT_HIT, 1'b0);
        // line b fills the other way of set 5
        add_entry(make_addr(2, 5, 1, 0), EXPECT_MISS, 1'b0);
        add_entry(make_addr(1, 5, 0, 0), EXPECT_HIT, 1'b0);
        add_entry(make_addr(2, 5, 3, 0), EXPECT_HIT, 1'b0);
        // line c evicts a or b
        add_entry(make_addr(3, 5, 0, 0), EXPECT_MISS, 1'b0);
        add_entry(make_addr(3, 5, 2, 0), EXPECT_HIT, 1'b0);
        evict_first = tab_addr.size();
        add_entry(make_addr(1, 5, 1, 0), EXPECT_EITHER, 1'b0);
        add_entry(make_addr(2, 5, 2, 0), EXPECT_EITHER, 1'b0);
        // flushed miss, then the same word again
        add_entry(make_addr(4, 9, 1, 0), EXPECT_MISS, 1'b1);
        add_entry(make_addr(4, 9, 1, 0), EXPECT_EITHER, 1'b0);
        // mixed traffic, five tags over three sets
        for (int i = 0; i < 48; i++) begin
            index = (i % 3 == 0) ? index_t'(5) : ((i % 3 == 1) ? index_t'(9) : index_t'(300));
            add_entry(make_addr(tag_t'(1 + (i * 7) % 5), index, bank_t'((i * 3) % 4),
                                4'(i % 16)), EXPECT_EITHER, 1'b0);
        end
    endtask

    // one falling edge, then what memory did at the rising edge before it
    task automatic tick();
        @(negedge clock);
        if (req_seen && mem_req_ready) begin
            mem_accepts++;
            last_req_addr = req_seen_addr;
        end else if (req_seen && mem_req_valid) begin
            check_addr(mem_req_addr, req_seen_addr, "mem_req_addr while waiting");
        end
        req_seen      = mem_req_valid;
        req_seen_addr = mem_req_addr;
    endtask

    task automatic flush_request();
        // wait for the line read to go out
        while (!mem_req_valid) begin
            check_flag(fetch_done, 1'b0, "fetch_done before flush");
            tick();
        end
        flush = 1'b1;
        tick();
        flush = 1'b0;
        // no done for it, ready once memory is quiet again
        while (!fetch_ready) begin
            check_flag(fetch_done, 1'b0, "fetch_done for a flushed fetch");
            tick();
        end
    endtask

    task automatic run_entry(input int idx);
        int   edges;
        int   accepts_at_start;
        logic missed;
        while (!fetch_ready) tick();
        fetch_valid      = 1'b1;
        fetch_addr       = tab_addr[idx];
        accepts_at_start = mem_accepts;
        // accept edge
        tick();
        fetch_valid = 1'b0;
        if (tab_flush[idx]) begin
            flush_request();
            seen_miss.push_back(1'b1);
        end else begin
            edges = 0;
            while (!fetch_done) begin
                // data bus stays zero until done
                check_word(fetch_data, '0);
                tick();
                edges++;
            end
            missed = (mem_accepts != accepts_at_start);
            seen_miss.push_back(missed);
            check_word(fetch_data, tab_word[idx]);
            if (tab_outcome[idx] != EXPECT_EITHER)
                check_miss(missed, tab_outcome[idx] == EXPECT_MISS, "fetch outcome");
            if (missed)
                check_addr(last_req_addr, tab_addr[idx] & 32'hFFFF_FFC0, "mem_req_addr");
            else
                check_cycles(edges, 2);
        end
    endtask

    task automatic watchdog();
        repeat (tab_addr.size() * 40 + 16) @(posedge clock);
        fail_run("simulation timed out waiting for the cache");
    endtask

    initial begin
        clock         = 1'b0;
        reset_n       = 1'b0;
        flush         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_addr    = '0;
        mem_accepts   = 0;
        req_seen      = 1'b0;
        req_seen_addr = '0;
        last_req_addr = '0;
        build_table();
        fork
            watchdog();
        join_none
        repeat (8) tick();
        reset_n = 1'b1;
        tick();
        check_flag(fetch_ready, 1'b1, "fetch_ready after reset");
        check_flag(mem_req_valid, 1'b0, "mem_req_valid after reset");
        for (int i = 0; i < tab_addr.size(); i++) begin
            run_entry(i);
            // one of lines a and b was evicted by line c
            if (i == evict_first + 1)
                check_miss(seen_miss[evict_first] || seen_miss[i], 1'b1, "evicted refetch");
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* list.f */
source/icache_pkg.sv
source/icache_tag_array.sv
source/icache_data_array.sv
source/icache_refill_unit.sv
source/icache_lookup_ctrl.sv
source/icache_top.sv
tests/icache_mem_model.sv
tests/icache_tb.sv
